// File: common/qpu_defs.svh
`ifndef QPU_DEFS_SVH
`define QPU_DEFS_SVH

// Classical datapath
`define QPU_XLEN          32
`define QPU_INSTR_SIZE    32
`define QPU_RFIDX_WIDTH   4   // 16 registers with r0 reading zero

// Quantum side
`define QPU_SIDX_WIDTH    3   // 8 mask registers
`define QPU_QUBIT_NUM     8
`define QPU_QIDX_WIDTH    3
`define QPU_TIME_WIDTH    20
`define QPU_GATE_WIDTH    8

// Outstanding measurements
`define QPU_OITF_DEPTH    4

// Opcodes with 0 as the no-op
`define QPU_OPC_WIDTH     4
`define QPU_OPC_NOP       4'd0
`define QPU_OPC_ADDI      4'd1
`define QPU_OPC_ADD       4'd2
`define QPU_OPC_SMIS      4'd3
`define QPU_OPC_QWAIT     4'd4
`define QPU_OPC_QOP       4'd5
`define QPU_OPC_MEASURE   4'd6
`define QPU_OPC_FMR       4'd7

`endif

// File: common/qpu_issue_if.sv
`timescale 1ns/10ps
`default_nettype none
`include "qpu_defs.svh"

interface qpu_issue_if;
  logic                        valid;
  logic                        ready;
  logic [`QPU_OPC_WIDTH-1:0]   opcode;
  logic [`QPU_XLEN-1:0]        opa;       // rs1 value or FMR qubit index
  logic [`QPU_XLEN-1:0]        opb;       // rs2 value or immediate
  logic [`QPU_RFIDX_WIDTH-1:0] rd;
  logic [`QPU_QUBIT_NUM-1:0]   mask;
  logic [`QPU_GATE_WIDTH-1:0]  gate;
  logic [`QPU_TIME_WIDTH-1:0]  wait_cnt;

  // Dispatch side
  modport src (
    output valid, opcode, opa, opb, rd, mask, gate, wait_cnt,
    input  ready
  );

  // Execute side
  modport dst (
    input  valid, opcode, opa, opb, rd, mask, gate, wait_cnt,
    output ready
  );
endinterface

`default_nettype wire

// File: common/qpu_pkg.sv
`default_nettype none
`include "qpu_defs.svh"

package qpu_pkg;

  // Classical format for ADDI and ADD
  typedef struct packed {
    logic [`QPU_OPC_WIDTH-1:0]   opcode;
    logic [`QPU_RFIDX_WIDTH-1:0] rd;
    logic [`QPU_RFIDX_WIDTH-1:0] rs1;
    logic [`QPU_RFIDX_WIDTH-1:0] rs2;
    logic signed [15:0]          imm;
  } qpu_cls_fmt_t;

  // Quantum format for SMIS, QWAIT, QOP, MEASURE and FMR
  typedef struct packed {
    logic [`QPU_OPC_WIDTH-1:0]   opcode;
    logic [`QPU_GATE_WIDTH-1:0]  gate;
    logic [`QPU_SIDX_WIDTH-1:0]  sidx;
    logic [`QPU_RFIDX_WIDTH-1:0] rd;
    logic [`QPU_QIDX_WIDTH-1:0]  qidx;
    logic [9:0]                  imm;    // SMIS mask in [7:0], QWAIT count
  } qpu_q_fmt_t;

  // One instruction word seen in two formats with a shared opcode field
  typedef union packed {
    qpu_cls_fmt_t cls;
    qpu_q_fmt_t   q;
  } qpu_instr_u;

endpackage

`default_nettype wire

// File: compile.f
+incdir+common
+incdir+tests
common/qpu_pkg.sv
common/qpu_issue_if.sv
exu/qpu_exu_decode.sv
exu/qpu_exu_disp.sv
exu/qpu_exu_oitf.sv
exu/qpu_exu_alu.sv
exu/qpu_exu_regfile.sv
design/qpu_exu_top.sv
tests/tb_qpu_exu.sv

// File: design/qpu_exu_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "qpu_defs.svh"

module qpu_exu_top (
  input  logic                         clk,
  input  logic                         i_rst,
  input  logic                         i_instr_valid,
  output logic                         o_instr_ready,
  input  qpu_pkg::qpu_instr_u          i_instr,
  output logic                         o_evt_valid,
  input  logic                         i_evt_ready,
  output logic [`QPU_GATE_WIDTH-1:0]   o_evt_gate,
  output logic [`QPU_QUBIT_NUM-1:0]    o_evt_mask,
  output logic [`QPU_TIME_WIDTH-1:0]   o_evt_time,
  output logic                         o_evt_meas,
  input  logic                         i_meas_valid,
  input  logic [`QPU_QUBIT_NUM-1:0]    i_meas_data,
  output logic                         o_wb_valid,
  output logic [`QPU_RFIDX_WIDTH-1:0]  o_wb_rdidx,
  output logic [`QPU_XLEN-1:0]         o_wb_data
);

  ////////////////////////////////////////////////////////////////////////////
  // Decode outputs
  logic [`QPU_OPC_WIDTH-1:0]   dec_opcode;
  logic [`QPU_RFIDX_WIDTH-1:0] dec_rd, dec_rs1, dec_rs2;
  logic [`QPU_XLEN-1:0]        dec_imm;
  logic [`QPU_SIDX_WIDTH-1:0]  dec_sidx;
  logic [`QPU_QIDX_WIDTH-1:0]  dec_qidx;
  logic [`QPU_GATE_WIDTH-1:0]  dec_gate;
  logic [`QPU_QUBIT_NUM-1:0]   dec_mask_imm;
  logic [`QPU_TIME_WIDTH-1:0]  dec_wait;
  logic dec_rs1en, dec_rs2en, dec_rdwen, dec_event, dec_measure, dec_fmr;

  // Register file and table links
  logic [`QPU_RFIDX_WIDTH-1:0] rs1idx, rs2idx;
  logic [`QPU_XLEN-1:0]        rs1_data, rs2_data;
  logic [`QPU_SIDX_WIDTH-1:0]  sidx;
  logic                        smask_wen;
  logic [`QPU_QUBIT_NUM-1:0]   smask_wdata, smask_data;
  logic                        oitf_enq, oitf_full, oitf_match;
  logic [`QPU_QUBIT_NUM-1:0]   oitf_mask, oitf_query, head_mask, meas_reg;
  logic                        time_add_valid;
  logic [`QPU_TIME_WIDTH-1:0]  time_add, time_now;

  qpu_issue_if issue_if ();

  qpu_exu_decode decode_i (
    .i_instr(i_instr), .o_opcode(dec_opcode), .o_rd(dec_rd), .o_rs1(dec_rs1),
    .o_rs2(dec_rs2), .o_imm(dec_imm), .o_sidx(dec_sidx), .o_qidx(dec_qidx),
    .o_gate(dec_gate), .o_mask_imm(dec_mask_imm), .o_wait(dec_wait),
    .o_rs1en(dec_rs1en), .o_rs2en(dec_rs2en), .o_rdwen(dec_rdwen),
    .o_event(dec_event), .o_measure(dec_measure), .o_fmr(dec_fmr)
  );

  qpu_exu_disp disp_i (
    .clk(clk), .i_rst(i_rst), .i_instr_valid(i_instr_valid),
    .o_instr_ready(o_instr_ready), .i_opcode(dec_opcode), .i_rd(dec_rd),
    .i_rs1(dec_rs1), .i_rs2(dec_rs2), .i_imm(dec_imm), .i_sidx(dec_sidx),
    .i_qidx(dec_qidx), .i_gate(dec_gate), .i_mask_imm(dec_mask_imm),
    .i_wait(dec_wait), .i_rs1en(dec_rs1en), .i_rs2en(dec_rs2en),
    .i_rdwen(dec_rdwen), .i_event(dec_event), .i_measure(dec_measure),
    .i_fmr(dec_fmr), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
    .i_smask_data(smask_data), .i_wb_valid(o_wb_valid), .i_wb_rdidx(o_wb_rdidx),
    .i_wb_data(o_wb_data), .i_oitf_full(oitf_full), .i_oitf_match(oitf_match),
    .o_rs1idx(rs1idx), .o_rs2idx(rs2idx), .o_sidx(sidx), .o_smask_wen(smask_wen),
    .o_smask_wdata(smask_wdata), .o_oitf_enq(oitf_enq), .o_oitf_mask(oitf_mask),
    .o_oitf_query(oitf_query), .issue(issue_if.src)
  );

  qpu_exu_oitf oitf_i (
    .clk(clk), .i_rst(i_rst), .i_enq(oitf_enq), .i_enq_mask(oitf_mask),
    .i_ret(i_meas_valid), .i_query_mask(oitf_query), .o_full(oitf_full),
    .o_match(oitf_match), .o_head_mask(head_mask)
  );

  qpu_exu_alu alu_i (
    .i_meas_reg_data(meas_reg), .i_time(time_now), .i_evt_ready(i_evt_ready),
    .issue(issue_if.dst), .o_wb_valid(o_wb_valid), .o_wb_rdidx(o_wb_rdidx),
    .o_wb_data(o_wb_data), .o_time_add_valid(time_add_valid),
    .o_time_add(time_add), .o_evt_valid(o_evt_valid), .o_evt_gate(o_evt_gate),
    .o_evt_mask(o_evt_mask), .o_evt_time(o_evt_time), .o_evt_meas(o_evt_meas)
  );

  qpu_exu_regfile regfile_i (
    .clk(clk), .i_rst(i_rst), .i_rs1idx(rs1idx), .i_rs2idx(rs2idx),
    .i_sidx(sidx), .i_wb_valid(o_wb_valid), .i_wb_rdidx(o_wb_rdidx),
    .i_wb_data(o_wb_data), .i_smask_wen(smask_wen), .i_smask_wdata(smask_wdata),
    .i_time_add_valid(time_add_valid), .i_time_add(time_add),
    .i_meas_valid(i_meas_valid), .i_meas_data(i_meas_data),
    .i_head_mask(head_mask), .o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
    .o_smask_data(smask_data), .o_time(time_now), .o_meas_data(meas_reg)
  );

endmodule

`default_nettype wire

// File: exu/qpu_exu_alu.sv
`timescale 1ns/10ps
`default_nettype none
`include "qpu_defs.svh"

module qpu_exu_alu (
  input  logic [`QPU_QUBIT_NUM-1:0]    i_meas_reg_data,
  input  logic [`QPU_TIME_WIDTH-1:0]   i_time,
  input  logic                         i_evt_ready,
  qpu_issue_if.dst                     issue,
  output logic                         o_wb_valid,
  output logic [`QPU_RFIDX_WIDTH-1:0]  o_wb_rdidx,
  output logic [`QPU_XLEN-1:0]         o_wb_data,
  output logic                         o_time_add_valid,
  output logic [`QPU_TIME_WIDTH-1:0]   o_time_add,
  output logic                         o_evt_valid,
  output logic [`QPU_GATE_WIDTH-1:0]   o_evt_gate,
  output logic [`QPU_QUBIT_NUM-1:0]    o_evt_mask,
  output logic [`QPU_TIME_WIDTH-1:0]   o_evt_time,
  output logic                         o_evt_meas
);

  logic is_add;
  logic is_fmr;
  logic is_evt;

  assign is_add = (issue.opcode == `QPU_OPC_ADDI) || (issue.opcode == `QPU_OPC_ADD);
  assign is_fmr = (issue.opcode == `QPU_OPC_FMR);
  assign is_evt = (issue.opcode == `QPU_OPC_QOP) || (issue.opcode == `QPU_OPC_MEASURE);

  // Only the event port can hold the issue register
  assign issue.ready = !is_evt || i_evt_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Classical write-back
  assign o_wb_valid = issue.valid && (is_add || is_fmr);
  assign o_wb_rdidx = issue.rd;
  assign o_wb_data  = is_fmr ?
                      `QPU_XLEN'(i_meas_reg_data[issue.opa[`QPU_QIDX_WIDTH-1:0]]) :
                      issue.opa + issue.opb;

  // QWAIT advances time at the end of this cycle
  assign o_time_add_valid = issue.valid && (issue.opcode == `QPU_OPC_QWAIT);
  assign o_time_add       = issue.wait_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // Events held stable by the issue register until taken
  assign o_evt_valid = issue.valid && is_evt;
  assign o_evt_gate  = issue.gate;
  assign o_evt_mask  = issue.mask;
  assign o_evt_time  = i_time;            // Time cannot move while an event waits
  assign o_evt_meas  = (issue.opcode == `QPU_OPC_MEASURE);

endmodule

`default_nettype wire

// File: exu/qpu_exu_decode.sv
`timescale 1ns/10ps
`default_nettype none
`include "qpu_defs.svh"

module qpu_exu_decode (
  input  qpu_pkg::qpu_instr_u          i_instr,
  output logic [`QPU_OPC_WIDTH-1:0]    o_opcode,
  output logic [`QPU_RFIDX_WIDTH-1:0]  o_rd,
  output logic [`QPU_RFIDX_WIDTH-1:0]  o_rs1,
  output logic [`QPU_RFIDX_WIDTH-1:0]  o_rs2,
  output logic [`QPU_XLEN-1:0]         o_imm,
  output logic [`QPU_SIDX_WIDTH-1:0]   o_sidx,
  output logic [`QPU_QIDX_WIDTH-1:0]   o_qidx,
  output logic [`QPU_GATE_WIDTH-1:0]   o_gate,
  output logic [`QPU_QUBIT_NUM-1:0]    o_mask_imm,
  output logic [`QPU_TIME_WIDTH-1:0]   o_wait,
  output logic                         o_rs1en,
  output logic                         o_rs2en,
  output logic                         o_rdwen,
  output logic                         o_event,
  output logic                         o_measure,
  output logic                         o_fmr
);

  always_comb
  begin
    o_opcode   = i_instr.cls.opcode;
    o_rd       = '0;
    o_rs1      = '0;
    o_rs2      = '0;
    o_imm      = '0;
    o_sidx     = '0;
    o_qidx     = '0;
    o_gate     = '0;
    o_mask_imm = '0;
    o_wait     = '0;
    o_rs1en    = 1'b0;
    o_rs2en    = 1'b0;
    o_rdwen    = 1'b0;
    o_event    = 1'b0;
    o_measure  = 1'b0;
    o_fmr      = 1'b0;

    case (i_instr.cls.opcode)
      `QPU_OPC_ADDI, `QPU_OPC_ADD:
      begin
        o_rd    = i_instr.cls.rd;
        o_rs1   = i_instr.cls.rs1;
        o_rs1en = 1'b1;
        o_rdwen = 1'b1;
        if (i_instr.cls.opcode == `QPU_OPC_ADD)
        begin
          o_rs2   = i_instr.cls.rs2;
          o_rs2en = 1'b1;
        end
        else
          o_imm = {{(`QPU_XLEN-16){i_instr.cls.imm[15]}}, i_instr.cls.imm};  // Sign extend
      end
      `QPU_OPC_SMIS:
      begin
        o_sidx     = i_instr.q.sidx;
        o_mask_imm = i_instr.q.imm[`QPU_QUBIT_NUM-1:0];
      end
      `QPU_OPC_QWAIT: o_wait = `QPU_TIME_WIDTH'(i_instr.q.imm);  // Unsigned count
      `QPU_OPC_QOP, `QPU_OPC_MEASURE:
      begin
        o_sidx    = i_instr.q.sidx;
        o_gate    = i_instr.q.gate;
        o_event   = 1'b1;
        o_measure = (i_instr.q.opcode == `QPU_OPC_MEASURE);
      end
      `QPU_OPC_FMR:
      begin
        o_rd    = i_instr.q.rd;
        o_qidx  = i_instr.q.qidx;
        o_rdwen = 1'b1;
        o_fmr   = 1'b1;
      end
      default: o_opcode = `QPU_OPC_NOP;   // Unknown opcodes do nothing
    endcase
  end

endmodule

`default_nettype wire

// File: exu/qpu_exu_disp.sv
`timescale 1ns/10ps
`default_nettype none
`include "qpu_defs.svh"

module qpu_exu_disp (
  input  logic                         clk,
  input  logic                         i_rst,
  input  logic                         i_instr_valid,
  output logic                         o_instr_ready,
  input  logic [`QPU_OPC_WIDTH-1:0]    i_opcode,
  input  logic [`QPU_RFIDX_WIDTH-1:0]  i_rd,
  input  logic [`QPU_RFIDX_WIDTH-1:0]  i_rs1,
  input  logic [`QPU_RFIDX_WIDTH-1:0]  i_rs2,
  input  logic [`QPU_XLEN-1:0]         i_imm,
  input  logic [`QPU_SIDX_WIDTH-1:0]   i_sidx,
  input  logic [`QPU_QIDX_WIDTH-1:0]   i_qidx,
  input  logic [`QPU_GATE_WIDTH-1:0]   i_gate,
  input  logic [`QPU_QUBIT_NUM-1:0]    i_mask_imm,
  input  logic [`QPU_TIME_WIDTH-1:0]   i_wait,
  input  logic                         i_rs1en,
  input  logic                         i_rs2en,
  input  logic                         i_rdwen,
  input  logic                         i_event,
  input  logic                         i_measure,
  input  logic                         i_fmr,
  input  logic [`QPU_XLEN-1:0]         i_rs1_data,
  input  logic [`QPU_XLEN-1:0]         i_rs2_data,
  input  logic [`QPU_QUBIT_NUM-1:0]    i_smask_data,
  input  logic                         i_wb_valid,
  input  logic [`QPU_RFIDX_WIDTH-1:0]  i_wb_rdidx,
  input  logic [`QPU_XLEN-1:0]         i_wb_data,
  input  logic                         i_oitf_full,
  input  logic                         i_oitf_match,
  output logic [`QPU_RFIDX_WIDTH-1:0]  o_rs1idx,
  output logic [`QPU_RFIDX_WIDTH-1:0]  o_rs2idx,
  output logic [`QPU_SIDX_WIDTH-1:0]   o_sidx,
  output logic                         o_smask_wen,
  output logic [`QPU_QUBIT_NUM-1:0]    o_smask_wdata,
  output logic                         o_oitf_enq,
  output logic [`QPU_QUBIT_NUM-1:0]    o_oitf_mask,
  output logic [`QPU_QUBIT_NUM-1:0]    o_oitf_query,
  qpu_issue_if.src                     issue
);

  logic                 fwd_rs1;
  logic                 fwd_rs2;
  logic [`QPU_XLEN-1:0] rs1_val;
  logic [`QPU_XLEN-1:0] rs2_val;
  logic                 stall;
  logic                 accept;

  ////////////////////////////////////////////////////////////////////////////
  // Operand read with forwarding of the write-back in flight
  assign o_rs1idx = i_rs1;
  assign o_rs2idx = i_rs2;
  assign fwd_rs1  = i_wb_valid && (i_wb_rdidx == i_rs1) && (i_rs1 != '0);
  assign fwd_rs2  = i_wb_valid && (i_wb_rdidx == i_rs2) && (i_rs2 != '0);
  assign rs1_val  = !i_rs1en ? '0 : (fwd_rs1 ? i_wb_data : i_rs1_data);
  assign rs2_val  = !i_rs2en ? i_imm : (fwd_rs2 ? i_wb_data : i_rs2_data);  // ADDI takes imm

  ////////////////////////////////////////////////////////////////////////////
  // Measurement hazards
  assign o_oitf_query = i_fmr ? (`QPU_QUBIT_NUM'(1) << i_qidx) : '0;
  assign stall = (i_measure && i_oitf_full) || (i_fmr && i_oitf_match);

  // Issue register free when empty or draining this cycle
  assign o_instr_ready = !stall && (!issue.valid || issue.ready);
  assign accept        = i_instr_valid && o_instr_ready;

  assign o_sidx        = i_sidx;
  assign o_smask_wen   = accept && (i_opcode == `QPU_OPC_SMIS);
  assign o_smask_wdata = i_mask_imm;
  assign o_oitf_enq    = accept && i_measure;
  assign o_oitf_mask   = i_smask_data;

  always_ff @(posedge clk)
  begin
    if (i_rst)
      issue.valid <= 1'b0;
    else if (accept)
      issue.valid <= 1'b1;
    else if (issue.ready)
      issue.valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      issue.opcode   <= i_opcode;
      issue.opa      <= i_fmr ? `QPU_XLEN'(i_qidx) : rs1_val;
      issue.opb      <= rs2_val;
      issue.rd       <= i_rdwen ? i_rd : '0;
      issue.mask     <= i_event ? i_smask_data : '0;
      issue.gate     <= i_gate;
      issue.wait_cnt <= i_wait;
    end
  end

endmodule

`default_nettype wire

// File: exu/qpu_exu_oitf.sv
`timescale 1ns/10ps
`default_nettype none
`include "qpu_defs.svh"

module qpu_exu_oitf (
  input  logic                       clk,
  input  logic                       i_rst,
  input  logic                       i_enq,
  input  logic [`QPU_QUBIT_NUM-1:0]  i_enq_mask,
  input  logic                       i_ret,
  input  logic [`QPU_QUBIT_NUM-1:0]  i_query_mask,
  output logic                       o_full,
  output logic                       o_match,
  output logic [`QPU_QUBIT_NUM-1:0]  o_head_mask
);

  localparam int PTR_W = $clog2(`QPU_OITF_DEPTH);

  logic [`QPU_QUBIT_NUM-1:0] masks [`QPU_OITF_DEPTH];
  logic [PTR_W-1:0]          wr_ptr;
  logic [PTR_W-1:0]          rd_ptr;
  logic [PTR_W:0]            count;
  logic                      ret_ok;

  assign o_full      = (count == (PTR_W+1)'(`QPU_OITF_DEPTH));
  assign ret_ok      = i_ret && (count != '0);   // Stray result on empty table ignored
  assign o_head_mask = masks[rd_ptr];

  // Any valid entry sharing a qubit with the query
  always_comb
  begin
    logic [PTR_W-1:0] offs;
    o_match = 1'b0;
    for (int i = 0; i < `QPU_OITF_DEPTH; i++)
    begin
      offs = PTR_W'(i) - rd_ptr;
      if (((PTR_W+1)'(offs) < count) && |(masks[i] & i_query_mask))
        o_match = 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (i_rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (i_enq)
        wr_ptr <= wr_ptr + 1'b1;
      if (ret_ok)
        rd_ptr <= rd_ptr + 1'b1;
      if (i_enq && !ret_ok)
        count <= count + 1'b1;
      else if (!i_enq && ret_ok)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (i_enq)
      masks[wr_ptr] <= i_enq_mask;
  end

endmodule

`default_nettype wire

// File: exu/qpu_exu_regfile.sv
`timescale 1ns/10ps
`default_nettype none
`include "qpu_defs.svh"

module qpu_exu_regfile (
  input  logic                         clk,
  input  logic                         i_rst,
  input  logic [`QPU_RFIDX_WIDTH-1:0]  i_rs1idx,
  input  logic [`QPU_RFIDX_WIDTH-1:0]  i_rs2idx,
  input  logic [`QPU_SIDX_WIDTH-1:0]   i_sidx,
  input  logic                         i_wb_valid,
  input  logic [`QPU_RFIDX_WIDTH-1:0]  i_wb_rdidx,
  input  logic [`QPU_XLEN-1:0]         i_wb_data,
  input  logic                         i_smask_wen,
  input  logic [`QPU_QUBIT_NUM-1:0]    i_smask_wdata,
  input  logic                         i_time_add_valid,
  input  logic [`QPU_TIME_WIDTH-1:0]   i_time_add,
  input  logic                         i_meas_valid,
  input  logic [`QPU_QUBIT_NUM-1:0]    i_meas_data,
  input  logic [`QPU_QUBIT_NUM-1:0]    i_head_mask,
  output logic [`QPU_XLEN-1:0]         o_rs1_data,
  output logic [`QPU_XLEN-1:0]         o_rs2_data,
  output logic [`QPU_QUBIT_NUM-1:0]    o_smask_data,
  output logic [`QPU_TIME_WIDTH-1:0]   o_time,
  output logic [`QPU_QUBIT_NUM-1:0]    o_meas_data
);

  localparam int NUM_XREG = 1 << `QPU_RFIDX_WIDTH;
  localparam int NUM_SREG = 1 << `QPU_SIDX_WIDTH;

  logic [`QPU_XLEN-1:0]       xregs [NUM_XREG];
  logic [`QPU_QUBIT_NUM-1:0]  sregs [NUM_SREG];
  logic [`QPU_TIME_WIDTH-1:0] time_q;
  logic [`QPU_QUBIT_NUM-1:0]  meas_q;

  assign o_rs1_data   = xregs[i_rs1idx];   // r0 is never written
  assign o_rs2_data   = xregs[i_rs2idx];
  assign o_smask_data = sregs[i_sidx];
  assign o_time       = time_q;
  assign o_meas_data  = meas_q;

  always_ff @(posedge clk)
  begin
    if (i_rst)
    begin
      for (int i = 0; i < NUM_XREG; i++)
        xregs[i] <= '0;
      for (int i = 0; i < NUM_SREG; i++)
        sregs[i] <= '0;
      time_q <= '0;
      meas_q <= '0;
    end
    else
    begin
      if (i_wb_valid && (i_wb_rdidx != '0))
        xregs[i_wb_rdidx] <= i_wb_data;
      if (i_smask_wen)
        sregs[i_sidx] <= i_smask_wdata;   // SMIS write shares the read index
      if (i_time_add_valid)
        time_q <= time_q + i_time_add;
      // Merge only the qubits of the oldest measurement
      if (i_meas_valid)
        meas_q <= (meas_q & ~i_head_mask) | (i_meas_data & i_head_mask);
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the execution unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module tb_qpu_exu -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_qpu_exu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
  exit 1
fi
exit 0

// File: tests/tb_qpu_exu_table.svh
`ifndef TB_QPU_EXU_TABLE_SVH
`define TB_QPU_EXU_TABLE_SVH

// Each row holds an instruction, the random event-ready gap flag, the reply
// delay (0 for none), the reply data and the expected completion kind
task automatic fill_table();
  // ADDI/ADD chain where each result feeds the next instruction
  add_row(enc_cls(`QPU_OPC_ADDI, 1, 0, 0, 16'd5),      0, 0, 8'h00, K_WB);
  add_row(enc_cls(`QPU_OPC_ADDI, 2, 1, 0, -16'sd3),    0, 0, 8'h00, K_WB);
  add_row(enc_cls(`QPU_OPC_ADD,  3, 1, 2, 16'd0),      0, 0, 8'h00, K_WB);
  add_row(enc_cls(`QPU_OPC_ADD,  4, 3, 3, 16'd0),      0, 0, 8'h00, K_WB);
  add_row(enc_cls(`QPU_OPC_ADDI, 0, 4, 0, 16'd9),      0, 0, 8'h00, K_WB);  // r0 stays zero
  add_row(enc_cls(`QPU_OPC_ADD,  5, 0, 4, 16'd0),      0, 0, 8'h00, K_WB);
  add_row(enc_cls(`QPU_OPC_ADDI, 6, 5, 0, 16'h8000),   0, 0, 8'h00, K_WB);

  // Masks, time and events
  add_row(enc_q(`QPU_OPC_SMIS,    8'h00, 1, 0, 0, 10'h0a5), 0, 0, 8'h00, K_NONE);
  add_row(enc_q(`QPU_OPC_SMIS,    8'h00, 2, 0, 0, 10'h00f), 0, 0, 8'h00, K_NONE);
  add_row(enc_q(`QPU_OPC_QWAIT,   8'h00, 0, 0, 0, 10'd100), 0, 0, 8'h00, K_NONE);
  add_row(enc_q(`QPU_OPC_QOP,     8'h11, 1, 0, 0, 10'd0),   0, 0, 8'h00, K_EVT);
  add_row(enc_q(`QPU_OPC_QWAIT,   8'h00, 0, 0, 0, 10'd37),  0, 0, 8'h00, K_NONE);
  add_row(enc_q(`QPU_OPC_MEASURE, 8'h22, 2, 0, 0, 10'd0),   0, 0, 8'h00, K_EVT);

  // Random event-ready gaps
  add_row(enc_q(`QPU_OPC_QOP,     8'h33, 1, 0, 0, 10'd0),   1, 0, 8'h00, K_EVT);
  add_row(enc_q(`QPU_OPC_QOP,     8'h44, 2, 0, 0, 10'd0),   1, 0, 8'h00, K_EVT);
  add_row(enc_q(`QPU_OPC_QWAIT,   8'h00, 0, 0, 0, 10'h3ff), 0, 0, 8'h00, K_NONE);
  add_row(enc_q(`QPU_OPC_QOP,     8'h55, 1, 0, 0, 10'd0),   1, 0, 8'h00, K_EVT);
  add_row(enc_q(`QPU_OPC_QOP,     8'h66, 2, 0, 0, 10'd0),   1, 0, 8'h00, K_EVT);

  // FMR hazards and a full outstanding table
  add_row(enc_q(`QPU_OPC_FMR,     8'h00, 0, 7, 1, 10'd0),   0, 3, 8'hff, K_WB);
  add_row(enc_q(`QPU_OPC_FMR,     8'h00, 0, 8, 5, 10'd0),   0, 0, 8'h00, K_WB);
  add_row(enc_q(`QPU_OPC_SMIS,    8'h00, 3, 0, 0, 10'h001), 0, 0, 8'h00, K_NONE);
  add_row(enc_q(`QPU_OPC_SMIS,    8'h00, 4, 0, 0, 10'h002), 0, 0, 8'h00, K_NONE);
  add_row(enc_q(`QPU_OPC_SMIS,    8'h00, 5, 0, 0, 10'h004), 0, 0, 8'h00, K_NONE);
  add_row(enc_q(`QPU_OPC_SMIS,    8'h00, 6, 0, 0, 10'h008), 0, 0, 8'h00, K_NONE);
  add_row(enc_q(`QPU_OPC_MEASURE, 8'h70, 3, 0, 0, 10'd0),   1, 0, 8'h00, K_EVT);
  add_row(enc_q(`QPU_OPC_MEASURE, 8'h71, 4, 0, 0, 10'd0),   0, 0, 8'h00, K_EVT);
  add_row(enc_q(`QPU_OPC_MEASURE, 8'h72, 5, 0, 0, 10'd0),   1, 0, 8'h00, K_EVT);
  add_row(enc_q(`QPU_OPC_MEASURE, 8'h73, 6, 0, 0, 10'd0),   0, 0, 8'h00, K_EVT);
  add_row(enc_q(`QPU_OPC_MEASURE, 8'h74, 3, 0, 0, 10'd0),   0, 4, 8'h00, K_EVT);  // Fifth
  add_row(enc_q(`QPU_OPC_FMR,     8'h00, 0, 9, 1, 10'd0),   0, 2, 8'h00, K_WB);
  add_row(enc_q(`QPU_OPC_FMR,     8'h00, 0, 10, 2, 10'd0),  0, 2, 8'h00, K_WB);
  add_row(enc_cls(`QPU_OPC_ADD,  11, 7, 10, 16'd0),    0, 0, 8'h00, K_WB);
  add_row(32'h0000_0000,                               0, 0, 8'h00, K_NONE);  // No-op
endtask

`endif

// File: tests/tb_qpu_exu.sv
`timescale 1ns/10ps
`default_nettype none
`include "qpu_defs.svh"

module tb_qpu_exu;

  localparam int K_NONE = 0;
  localparam int K_WB   = 1;
  localparam int K_EVT  = 2;

  typedef struct {
    logic [31:0] instr;
    bit          rdy_rand;
    int          meas_delay;
    logic [7:0]  meas_data;
    int          exp_kind;
  } row_t;

  logic clk = 1'b0;
  logic i_rst, i_instr_valid, i_evt_ready, i_meas_valid;
  qpu_pkg::qpu_instr_u i_instr;
  logic [7:0]  i_meas_data;
  logic        o_instr_ready, o_evt_valid, o_evt_meas, o_wb_valid;
  logic [7:0]  o_evt_gate, o_evt_mask;
  logic [19:0] o_evt_time;
  logic [3:0]  o_wb_rdidx;
  logic [31:0] o_wb_data;

  row_t rows[$];
  int   row_err[];
  int   seed, cycles, limit, err_total, tests_failed;

  // Reference model state
  logic [31:0] m_x [16];
  logic [7:0]  m_s [8];
  logic [19:0] m_time;
  logic [7:0]  m_meas;
  logic [7:0]  m_oitf[$];

  // Expected completion of the instruction in the issue register
  bit          pend_active;
  int          pend_kind, pend_row, gap;
  logic [31:0] exp_a, exp_b, exp_c, exp_d;

  always #4 clk = ~clk;

  qpu_exu_top dut_i (
    .clk(clk), .i_rst(i_rst), .i_instr_valid(i_instr_valid),
    .o_instr_ready(o_instr_ready), .i_instr(i_instr), .o_evt_valid(o_evt_valid),
    .i_evt_ready(i_evt_ready), .o_evt_gate(o_evt_gate), .o_evt_mask(o_evt_mask),
    .o_evt_time(o_evt_time), .o_evt_meas(o_evt_meas), .i_meas_valid(i_meas_valid),
    .i_meas_data(i_meas_data), .o_wb_valid(o_wb_valid), .o_wb_rdidx(o_wb_rdidx),
    .o_wb_data(o_wb_data)
  );

  function automatic logic [31:0] enc_cls(input logic [3:0] opc, input logic [3:0] rd,
                                          input logic [3:0] rs1, input logic [3:0] rs2,
                                          input logic [15:0] imm);
    return {opc, rd, rs1, rs2, imm};
  endfunction

  function automatic logic [31:0] enc_q(input logic [3:0] opc, input logic [7:0] gate,
                                        input logic [2:0] sidx, input logic [3:0] rd,
                                        input logic [2:0] qidx, input logic [9:0] imm);
    return {opc, gate, sidx, rd, qidx, imm};
  endfunction

  task automatic add_row(input logic [31:0] instr, input bit rnd, input int delay,
                         input logic [7:0] data, input int kind);
    row_t r;
    r.instr      = instr;
    r.rdy_rand   = rnd;
    r.meas_delay = delay;
    r.meas_data  = data;
    r.exp_kind   = kind;
    rows.push_back(r);
  endtask

  `include "tb_qpu_exu_table.svh"

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp, input int row);
    assert (got === exp)
    else
    begin
      $display("ERROR time %0t row %0d %s: expected 0x%0h, got 0x%0h",
               $time, row, name, exp, got);
      row_err[row]++;
      err_total++;
    end
  endtask

  task automatic check_true(input bit cond, input string msg, input int row);
    assert (cond)
    else
    begin
      $display("Failure at time %0t in row %0d: %s", $time, row, msg);
      row_err[row]++;
      err_total++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model

  function automatic bit model_stall(input qpu_pkg::qpu_instr_u u);
    bit hit;
    hit = 1'b0;
    if (u.q.opcode == `QPU_OPC_MEASURE)
      hit = (m_oitf.size() >= `QPU_OITF_DEPTH);
    else if (u.q.opcode == `QPU_OPC_FMR)
      foreach (m_oitf[i])
        if (m_oitf[i][u.q.qidx])
          hit = 1'b1;
    return hit;
  endfunction

  task automatic model_retire(input logic [7:0] data);
    logic [7:0] head;
    head   = m_oitf.pop_front();
    m_meas = (m_meas & ~head) | (data & head);
  endtask

  task automatic model_exec(input int r);
    qpu_pkg::qpu_instr_u u;
    logic [31:0] sum;
    u = rows[r].instr;
    pend_kind = K_NONE;
    case (u.cls.opcode)
      `QPU_OPC_ADDI, `QPU_OPC_ADD:
      begin
        if (u.cls.opcode == `QPU_OPC_ADD)
          sum = m_x[u.cls.rs1] + m_x[u.cls.rs2];
        else
          sum = m_x[u.cls.rs1] + {{16{u.cls.imm[15]}}, u.cls.imm};
        pend_kind = K_WB;
        exp_a = u.cls.rd;
        exp_b = sum;
        if (u.cls.rd != 0)
          m_x[u.cls.rd] = sum;
      end
      `QPU_OPC_SMIS:  m_s[u.q.sidx] = u.q.imm[7:0];
      `QPU_OPC_QWAIT: m_time = m_time + 20'(u.q.imm);
      `QPU_OPC_QOP, `QPU_OPC_MEASURE:
      begin
        pend_kind = K_EVT;
        exp_a = u.q.gate;
        exp_b = m_s[u.q.sidx];
        exp_c = m_time;
        exp_d = (u.q.opcode == `QPU_OPC_MEASURE);
        if (u.q.opcode == `QPU_OPC_MEASURE)
          m_oitf.push_back(m_s[u.q.sidx]);
      end
      `QPU_OPC_FMR:
      begin
        pend_kind = K_WB;
        exp_a = u.q.rd;
        exp_b = 32'(m_meas[u.q.qidx]);
        if (u.q.rd != 0)
          m_x[u.q.rd] = exp_b;
      end
      default: pend_kind = K_NONE;
    endcase
    check_true(pend_kind == rows[r].exp_kind, "table kind differs from the model", r);
    pend_active = 1'b1;
    pend_row    = r;
    gap         = rows[r].rdy_rand ? ($unsigned($random(seed)) % 4) : 0;
  endtask

  // Run limit from the table length
  always @(posedge clk)
  begin
    cycles++;
    if (limit > 0 && cycles > limit)
    begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  initial
  begin
    int  pres, done_rows, wait_n, n;
    bit  accepted, done_now, stall_pred, meas_sent, meas_drv;
    logic [7:0] meas_drv_data;

    seed = 95366;
    cycles = 0;
    limit = 0;
    i_rst = 1'b1;
    i_instr_valid = 1'b0;
    i_instr = '0;
    i_evt_ready = 1'b0;
    i_meas_valid = 1'b0;
    i_meas_data = '0;
    foreach (m_x[i])
      m_x[i] = '0;
    foreach (m_s[i])
      m_s[i] = '0;
    m_time = '0;
    m_meas = '0;
    pend_active = 1'b0;
    fill_table();
    n = rows.size();
    row_err = new[n + 1];     // Last slot is the reset test
    limit = n * 20;

    repeat (10) @(posedge clk);
    i_rst <= 1'b0;

    @(negedge clk);
    check_true(o_instr_ready === 1'b1, "o_instr_ready low after reset", n);
    check_true(o_evt_valid === 1'b0, "o_evt_valid high after reset", n);
    check_true(o_wb_valid === 1'b0, "o_wb_valid high after reset", n);
    $display("test reset: %s", (row_err[n] == 0) ? "ok" : "FAILED");
    if (row_err[n] != 0)
      tests_failed++;

    @(posedge clk);
    i_instr_valid <= 1'b1;
    i_instr       <= rows[0].instr;
    pres = 0;
    done_rows = 0;
    wait_n = 0;
    meas_sent = 0;
    meas_drv = 0;

    while (done_rows < n)
    begin
      @(negedge clk);
      done_now = 0;
      if (pend_active && pend_kind == K_WB)
      begin
        check_val("o_wb_valid", o_wb_valid, 1, pend_row);
        check_val("o_wb_rdidx", o_wb_rdidx, exp_a, pend_row);
        check_val("o_wb_data", o_wb_data, exp_b, pend_row);
        check_val("o_evt_valid", o_evt_valid, 0, pend_row);
        done_now = 1;
      end
      else if (pend_active && pend_kind == K_EVT)
      begin
        check_val("o_evt_valid", o_evt_valid, 1, pend_row);
        check_val("o_evt_gate", o_evt_gate, exp_a, pend_row);
        check_val("o_evt_mask", o_evt_mask, exp_b, pend_row);
        check_val("o_evt_time", o_evt_time, exp_c, pend_row);
        check_val("o_evt_meas", o_evt_meas, exp_d, pend_row);
        check_val("o_wb_valid", o_wb_valid, 0, pend_row);
        done_now = i_evt_ready;
      end
      else
      begin
        // Nothing visible may come out of a silent or empty issue slot
        check_val("o_wb_valid", o_wb_valid, 0, pend_active ? pend_row : n);
        check_val("o_evt_valid", o_evt_valid, 0, pend_active ? pend_row : n);
        done_now = pend_active;
      end

      accepted = 0;
      if (pres < n)
      begin
        stall_pred = model_stall(rows[pres].instr);
        accepted   = o_instr_ready;
        check_true(!(accepted && stall_pred),
                   "instruction accepted while its hazard was pending", pres);
        check_true(!(accepted && pend_active && pend_kind == K_EVT && !i_evt_ready),
                   "instruction accepted while an event was still waiting", pres);
        check_true(accepted || stall_pred ||
                   (pend_active && pend_kind == K_EVT && !i_evt_ready),
                   "instruction held back with no hazard and no waiting event", pres);
        if (!accepted)
          wait_n++;
      end

      @(posedge clk);
      if (meas_drv)
      begin
        model_retire(meas_drv_data);
        meas_drv = 0;
      end
      i_meas_valid <= 1'b0;
      if (done_now)
      begin
        $display("test %0d opcode %0d: %s", pend_row, rows[pend_row].instr[31:28],
                 (row_err[pend_row] == 0) ? "ok" : "FAILED");
        if (row_err[pend_row] != 0)
          tests_failed++;
        pend_active = 0;
        done_rows++;
      end
      if (accepted)
      begin
        check_true(rows[pres].meas_delay == 0 || meas_sent,
                   "accepted before its measurement reply was sent", pres);
        model_exec(pres);
        pres++;
        wait_n = 0;
        meas_sent = 0;
        if (pres < n)
          i_instr <= rows[pres].instr;
        else
          i_instr_valid <= 1'b0;
      end
      else if (pres < n && rows[pres].meas_delay > 0 && !meas_sent &&
               wait_n >= rows[pres].meas_delay)
      begin
        i_meas_valid  <= 1'b1;
        i_meas_data   <= rows[pres].meas_data;
        meas_drv      = 1;
        meas_drv_data = rows[pres].meas_data;
        meas_sent     = 1;
      end
      if (pend_active && pend_kind == K_EVT)
      begin
        if (gap > 0)
        begin
          i_evt_ready <= 1'b0;
          gap--;
        end
        else
          i_evt_ready <= 1'b1;
      end
      else
        i_evt_ready <= 1'b0;
    end

    @(negedge clk);
    check_true(o_evt_valid === 1'b0 && o_wb_valid === 1'b0,
               "output still valid after the last instruction", n);
    $display("tests: %0d, failed: %0d, errors: %0d", n + 1, tests_failed, err_total);
    if (err_total == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire
